//--- source/pdp_rdma_cfg.svh
// widths, register byte offsets and enable delay depth
// for the pooling read-dma register file
`ifndef PDP_RDMA_CFG_SVH
`define PDP_RDMA_CFG_SVH

// data path widths
`define PDP_RDMA_DATA_W       32   // register data
`define PDP_RDMA_ADDR_W       22   // csb word address
`define PDP_RDMA_OFFS_W       12   // decoded byte offset bits
`define PDP_RDMA_CUBE_W       13   // cube dimension fields
`define PDP_RDMA_OP_EN_DELAY  3    // stages on reg2dp_op_en

// single group
`define PDP_RDMA_S_POINTER          12'h000
`define PDP_RDMA_S_STATUS           12'h004

// dual groups, op_enable is also the group boundary
`define PDP_RDMA_D_OP_ENABLE        12'h008
`define PDP_RDMA_D_CUBE_WIDTH       12'h00c
`define PDP_RDMA_D_CUBE_HEIGHT      12'h010
`define PDP_RDMA_D_CUBE_CHANNEL     12'h014
`define PDP_RDMA_D_DMA_EN           12'h018
`define PDP_RDMA_D_SRC_BASE_LOW     12'h01c
`define PDP_RDMA_D_SRC_LINE_STRIDE  12'h020

`endif

//--- source/pdp_rdma_csb_pkg.sv
// csb packet types
// request layout, response layout and response kind
`include "pdp_rdma_cfg.svh"

package pdp_rdma_csb_pkg;

  // response id bit
  typedef enum logic {
    RESP_READ  = 1'b0,
    RESP_WRITE = 1'b1
  } resp_kind_e;

  // request, first member is msb, addr sits at bit 0
  typedef struct packed {
    logic [1:0]                   level;    // 62:61
    logic [3:0]                   wrbe;     // 60:57
    logic                         srcpriv;  // 56
    logic                         nposted;  // 55, write wants a response
    logic                         write;    // 54
    logic [`PDP_RDMA_DATA_W-1:0]  wdat;     // 53:22
    logic [`PDP_RDMA_ADDR_W-1:0]  addr;     // 21:0, word address
  } csb_req_t;

  // response, 34 bits
  typedef struct packed {
    resp_kind_e                   kind;     // 33
    logic                         error;    // 32
    logic [`PDP_RDMA_DATA_W-1:0]  rdat;     // 31:0
  } csb_resp_t;

endpackage

//--- source/pdp_rdma_reg_pkg.sv
// register side types
// per-group layer configuration and group status code
`include "pdp_rdma_cfg.svh"

package pdp_rdma_reg_pkg;

  // one group's configuration, as seen by the datapath
  typedef struct packed {
    logic [`PDP_RDMA_CUBE_W-1:0]  cube_in_width;
    logic [`PDP_RDMA_CUBE_W-1:0]  cube_in_height;
    logic [`PDP_RDMA_CUBE_W-1:0]  cube_in_channel;
    logic                         dma_en;
    logic [`PDP_RDMA_DATA_W-1:0]  src_base_addr_low;
    logic [`PDP_RDMA_DATA_W-1:0]  src_line_stride;
  } cfg_t;

  // status field per group in the status word
  typedef enum logic [1:0] {
    GRP_IDLE    = 2'd0,   // op_en clear
    GRP_RUNNING = 2'd1,   // op_en set, consumer here
    GRP_PENDING = 2'd2    // op_en set, other group consumed
  } group_status_e;

endpackage

//--- source/pdp_rdma_reg_if.sv
// register access bus between the csb slave and one register group
`timescale 1ns/1ps
`include "pdp_rdma_cfg.svh"

interface pdp_rdma_reg_if;

  logic [`PDP_RDMA_OFFS_W-1:0]  offset;    // byte offset
  logic [`PDP_RDMA_DATA_W-1:0]  wr_data;
  logic                         wr_en;     // already qualified by group select
  logic [`PDP_RDMA_DATA_W-1:0]  rd_data;   // combinational from offset

  modport master (
    output offset, wr_data, wr_en,
    input  rd_data
  );

  modport slave (
    input  offset, wr_data, wr_en,
    output rd_data
  );

endinterface

//--- source/pdp_rdma_csb_slave.sv
// csb slave for the pdp rdma register file
// request capture, group decode, read mux and response packing
`timescale 1ns/1ps
`include "pdp_rdma_cfg.svh"

module pdp_rdma_csb_slave (
  input  logic                         nvdla_core_clk,
  input  logic                         nvdla_core_rstn,
  input  logic                         req_pvld,
  input  pdp_rdma_csb_pkg::csb_req_t   req_pd,
  output logic                         req_prdy,
  output logic                         resp_valid,
  output pdp_rdma_csb_pkg::csb_resp_t  resp_pd,
  input  logic                         producer,   // dual group written by sw
  pdp_rdma_reg_if.master               s_if,
  pdp_rdma_reg_if.master               d0_if,
  pdp_rdma_reg_if.master               d1_if
);

  logic                         req_vld_q;
  pdp_rdma_csb_pkg::csb_req_t   req_q;
  logic [`PDP_RDMA_OFFS_W-1:0]  offset;
  logic                         wr_en;
  logic                         rd_en;
  logic                         sel_s;
  logic                         sel_d0;
  logic                         sel_d1;
  logic [`PDP_RDMA_DATA_W-1:0]  rd_data;

  assign req_prdy = 1'b1;   // never stalls

  ////////////////////////////////////////
  // request capture
  ////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      req_vld_q <= 1'b0;
    end else begin
      req_vld_q <= req_pvld;
    end
  end

  always_ff @(posedge nvdla_core_clk) begin
    if (req_pvld) begin
      req_q <= req_pd;   // payload only
    end
  end

  // word address to byte offset
  assign offset = {req_q.addr[`PDP_RDMA_OFFS_W-3:0], 2'b00};
  assign wr_en  = req_vld_q & req_q.write;
  assign rd_en  = req_vld_q & ~req_q.write;

  ////////////////////////////////////////
  // group decode
  ////////////////////////////////////////
  assign sel_s  = (offset < `PDP_RDMA_D_OP_ENABLE);
  assign sel_d0 = ~sel_s & ~producer;
  assign sel_d1 = ~sel_s & producer;

  assign s_if.offset   = offset;
  assign s_if.wr_data  = req_q.wdat;
  assign s_if.wr_en    = wr_en & sel_s;
  assign d0_if.offset  = offset;
  assign d0_if.wr_data = req_q.wdat;
  assign d0_if.wr_en   = wr_en & sel_d0;
  assign d1_if.offset  = offset;
  assign d1_if.wr_data = req_q.wdat;
  assign d1_if.wr_en   = wr_en & sel_d1;

  // one select is hot, or them together
  assign rd_data = ({`PDP_RDMA_DATA_W{sel_s}}  & s_if.rd_data)  |
                   ({`PDP_RDMA_DATA_W{sel_d0}} & d0_if.rd_data) |
                   ({`PDP_RDMA_DATA_W{sel_d1}} & d1_if.rd_data);

  ////////////////////////////////////////
  // response
  ////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= rd_en | (wr_en & req_q.nposted);   // posted writes stay silent
    end
  end

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      resp_pd <= '0;
    end else if (rd_en) begin
      resp_pd <= '{kind: pdp_rdma_csb_pkg::RESP_READ, error: 1'b0, rdat: rd_data};
    end else if (wr_en & req_q.nposted) begin
      resp_pd <= '{kind: pdp_rdma_csb_pkg::RESP_WRITE, error: 1'b0, rdat: '0};
    end
  end

endmodule

//--- source/pdp_rdma_single_reg.sv
// single register group
// producer pointer and read-only status word
`timescale 1ns/1ps
`include "pdp_rdma_cfg.svh"

module pdp_rdma_single_reg (
  input  logic             nvdla_core_clk,
  input  logic             nvdla_core_rstn,
  pdp_rdma_reg_if.slave    reg_if,
  input  logic             consumer,   // group the datapath works on
  input  logic             d0_op_en,
  input  logic             d1_op_en,
  output logic             producer    // group sw fills
);

  pdp_rdma_reg_pkg::group_status_e status_0;
  pdp_rdma_reg_pkg::group_status_e status_1;

  // status of one group given its enable and whether it is consumed
  function automatic pdp_rdma_reg_pkg::group_status_e grp_status(input logic op_en,
                                                                 input logic consumed);
    if (!op_en) begin
      return pdp_rdma_reg_pkg::GRP_IDLE;
    end
    return consumed ? pdp_rdma_reg_pkg::GRP_RUNNING : pdp_rdma_reg_pkg::GRP_PENDING;
  endfunction

  assign status_0 = grp_status(d0_op_en, ~consumer);
  assign status_1 = grp_status(d1_op_en, consumer);

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      producer <= 1'b0;
    end else if (reg_if.wr_en && reg_if.offset == `PDP_RDMA_S_POINTER) begin
      producer <= reg_if.wr_data[0];
    end
  end

  // read path, unmapped reads as zero
  always_comb begin
    reg_if.rd_data = '0;
    case (reg_if.offset)
      `PDP_RDMA_S_POINTER: reg_if.rd_data[0] = producer;
      `PDP_RDMA_S_STATUS: begin
        reg_if.rd_data[1:0]   = status_0;
        reg_if.rd_data[17:16] = status_1;
      end
      default: ;
    endcase
  end

endmodule

//--- source/pdp_rdma_dual_reg.sv
// one ping-pong configuration group
// layer fields, op enable and field read-back
`timescale 1ns/1ps
`include "pdp_rdma_cfg.svh"

module pdp_rdma_dual_reg (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  pdp_rdma_reg_if.slave            reg_if,
  input  logic                     done_clr,   // datapath finished this group
  output pdp_rdma_reg_pkg::cfg_t   cfg,
  output logic                     op_en
);

  logic wr_open;    // group accepts writes
  logic op_en_we;

  assign wr_open  = reg_if.wr_en & ~op_en;   // locked while enabled
  assign op_en_we = wr_open & (reg_if.offset == `PDP_RDMA_D_OP_ENABLE);

  ////////////////////////////////////////
  // op enable
  ////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en <= 1'b0;
    end else if (op_en_we) begin
      op_en <= reg_if.wr_data[0];
    end else if (done_clr) begin
      op_en <= 1'b0;
    end
  end

  ////////////////////////////////////////
  // configuration fields
  ////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      cfg <= '0;
    end else if (wr_open) begin
      case (reg_if.offset)
        `PDP_RDMA_D_CUBE_WIDTH:      cfg.cube_in_width   <= reg_if.wr_data[`PDP_RDMA_CUBE_W-1:0];
        `PDP_RDMA_D_CUBE_HEIGHT:     cfg.cube_in_height  <= reg_if.wr_data[`PDP_RDMA_CUBE_W-1:0];
        `PDP_RDMA_D_CUBE_CHANNEL:    cfg.cube_in_channel <= reg_if.wr_data[`PDP_RDMA_CUBE_W-1:0];
        `PDP_RDMA_D_DMA_EN:          cfg.dma_en          <= reg_if.wr_data[0];
        `PDP_RDMA_D_SRC_BASE_LOW:    cfg.src_base_addr_low <= reg_if.wr_data;
        `PDP_RDMA_D_SRC_LINE_STRIDE: cfg.src_line_stride <= reg_if.wr_data;
        default: ;   // op_enable and holes
      endcase
    end
  end

  ////////////////////////////////////////
  // read back
  ////////////////////////////////////////
  always_comb begin
    reg_if.rd_data = '0;
    case (reg_if.offset)
      `PDP_RDMA_D_OP_ENABLE:       reg_if.rd_data[0] = op_en;
      `PDP_RDMA_D_CUBE_WIDTH:      reg_if.rd_data[`PDP_RDMA_CUBE_W-1:0] = cfg.cube_in_width;
      `PDP_RDMA_D_CUBE_HEIGHT:     reg_if.rd_data[`PDP_RDMA_CUBE_W-1:0] = cfg.cube_in_height;
      `PDP_RDMA_D_CUBE_CHANNEL:    reg_if.rd_data[`PDP_RDMA_CUBE_W-1:0] = cfg.cube_in_channel;
      `PDP_RDMA_D_DMA_EN:          reg_if.rd_data[0] = cfg.dma_en;
      `PDP_RDMA_D_SRC_BASE_LOW:    reg_if.rd_data = cfg.src_base_addr_low;
      `PDP_RDMA_D_SRC_LINE_STRIDE: reg_if.rd_data = cfg.src_line_stride;
      default: ;   // unmapped reads zero
    endcase
  end

endmodule

//--- source/pdp_rdma_ping_pong_ctrl.sv
// ping-pong control
// consumer pointer, done clears, op_en delay line and config select
`timescale 1ns/1ps
`include "pdp_rdma_cfg.svh"

module pdp_rdma_ping_pong_ctrl (
  input  logic                     nvdla_core_clk,
  input  logic                     nvdla_core_rstn,
  input  logic                     dp2reg_done,   // layer finished
  input  pdp_rdma_reg_pkg::cfg_t   d0_cfg,
  input  pdp_rdma_reg_pkg::cfg_t   d1_cfg,
  input  logic                     d0_op_en,
  input  logic                     d1_op_en,
  output logic                     consumer,
  output logic                     d0_done_clr,
  output logic                     d1_done_clr,
  output pdp_rdma_reg_pkg::cfg_t   reg2dp_cfg,
  output logic                     reg2dp_op_en
);

  logic                              op_en_sel;    // enable of consumed group
  logic [`PDP_RDMA_OP_EN_DELAY-1:0]  op_en_pipe;

  ////////////////////////////////////////
  // consumer pointer
  ////////////////////////////////////////
  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      consumer <= 1'b0;
    end else if (dp2reg_done) begin
      consumer <= ~consumer;
    end
  end

  // clear goes to the group that just finished
  assign d0_done_clr = dp2reg_done & ~consumer;
  assign d1_done_clr = dp2reg_done & consumer;

  ////////////////////////////////////////
  // op_en delay line
  ////////////////////////////////////////
  assign op_en_sel = consumer ? d1_op_en : d0_op_en;

  always_ff @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    if (!nvdla_core_rstn) begin
      op_en_pipe <= '0;
    end else if (dp2reg_done) begin
      op_en_pipe <= '0;   // flush on done
    end else begin
      op_en_pipe <= {op_en_pipe[`PDP_RDMA_OP_EN_DELAY-2:0], op_en_sel};
    end
  end

  assign reg2dp_op_en = op_en_pipe[`PDP_RDMA_OP_EN_DELAY-1];

  // config follows consumer with no delay
  assign reg2dp_cfg = consumer ? d1_cfg : d0_cfg;

endmodule

//--- source/pdp_rdma_reg_top.sv
// pdp rdma register file top
// csb slave, single group, two dual groups, ping-pong control
`timescale 1ns/1ps
`include "pdp_rdma_cfg.svh"

module pdp_rdma_reg_top (
  input  logic                         nvdla_core_clk,
  input  logic                         nvdla_core_rstn,
  input  logic                         csb2pdp_rdma_req_pvld,
  input  logic [62:0]                  csb2pdp_rdma_req_pd,
  output logic                         csb2pdp_rdma_req_prdy,
  output logic                         pdp_rdma2csb_resp_valid,
  output logic [33:0]                  pdp_rdma2csb_resp_pd,
  input  logic                         dp2reg_done,
  output logic [`PDP_RDMA_CUBE_W-1:0]  reg2dp_cube_in_width,
  output logic [`PDP_RDMA_CUBE_W-1:0]  reg2dp_cube_in_height,
  output logic [`PDP_RDMA_CUBE_W-1:0]  reg2dp_cube_in_channel,
  output logic                         reg2dp_dma_en,
  output logic [`PDP_RDMA_DATA_W-1:0]  reg2dp_src_base_addr_low,
  output logic [`PDP_RDMA_DATA_W-1:0]  reg2dp_src_line_stride,
  output logic                         reg2dp_op_en
);

  logic                     producer;
  logic                     consumer;
  logic                     d0_op_en;
  logic                     d1_op_en;
  logic                     d0_done_clr;
  logic                     d1_done_clr;
  pdp_rdma_reg_pkg::cfg_t   d0_cfg;
  pdp_rdma_reg_pkg::cfg_t   d1_cfg;
  pdp_rdma_reg_pkg::cfg_t   reg2dp_cfg;   // consumed group

  pdp_rdma_reg_if s_if ();
  pdp_rdma_reg_if d0_if ();
  pdp_rdma_reg_if d1_if ();

  pdp_rdma_csb_slave u_csb_slave (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .req_pvld       (csb2pdp_rdma_req_pvld),
    .req_pd         (csb2pdp_rdma_req_pd),
    .req_prdy       (csb2pdp_rdma_req_prdy),
    .resp_valid     (pdp_rdma2csb_resp_valid),
    .resp_pd        (pdp_rdma2csb_resp_pd),
    .producer       (producer),
    .s_if           (s_if.master),
    .d0_if          (d0_if.master),
    .d1_if          (d1_if.master)
  );

  pdp_rdma_single_reg u_single_reg (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .reg_if         (s_if.slave),
    .consumer       (consumer),
    .d0_op_en       (d0_op_en),
    .d1_op_en       (d1_op_en),
    .producer       (producer)
  );

  pdp_rdma_dual_reg u_dual_reg_d0 (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .reg_if         (d0_if.slave),
    .done_clr       (d0_done_clr),
    .cfg            (d0_cfg),
    .op_en          (d0_op_en)
  );

  pdp_rdma_dual_reg u_dual_reg_d1 (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .reg_if         (d1_if.slave),
    .done_clr       (d1_done_clr),
    .cfg            (d1_cfg),
    .op_en          (d1_op_en)
  );

  pdp_rdma_ping_pong_ctrl u_ping_pong_ctrl (
    .nvdla_core_clk (nvdla_core_clk),
    .nvdla_core_rstn(nvdla_core_rstn),
    .dp2reg_done    (dp2reg_done),
    .d0_cfg         (d0_cfg),
    .d1_cfg         (d1_cfg),
    .d0_op_en       (d0_op_en),
    .d1_op_en       (d1_op_en),
    .consumer       (consumer),
    .d0_done_clr    (d0_done_clr),
    .d1_done_clr    (d1_done_clr),
    .reg2dp_cfg     (reg2dp_cfg),
    .reg2dp_op_en   (reg2dp_op_en)
  );

  // flatten config onto the datapath ports
  assign reg2dp_cube_in_width     = reg2dp_cfg.cube_in_width;
  assign reg2dp_cube_in_height    = reg2dp_cfg.cube_in_height;
  assign reg2dp_cube_in_channel   = reg2dp_cfg.cube_in_channel;
  assign reg2dp_dma_en            = reg2dp_cfg.dma_en;
  assign reg2dp_src_base_addr_low = reg2dp_cfg.src_base_addr_low;
  assign reg2dp_src_line_stride   = reg2dp_cfg.src_line_stride;

endmodule

//--- sim/pdp_rdma_reg_tb.sv
// testbench for the pdp rdma register file
// clock and reset, lcg stimulus, cycle model of the register file
// and per-cycle output checks
`timescale 1ns/1ps
`include "pdp_rdma_cfg.svh"

module pdp_rdma_reg_tb;

  localparam int wait_limit = 20;   // cycles before a wait gives up

  logic                        nvdla_core_clk;
  logic                        nvdla_core_rstn;
  logic                        req_pvld;
  pdp_rdma_csb_pkg::csb_req_t  req_pd;
  logic                        req_prdy;
  logic                        resp_valid;
  logic [33:0]                 resp_pd;
  logic                        dp2reg_done;
  logic [12:0]                 cube_w;
  logic [12:0]                 cube_h;
  logic [12:0]                 cube_c;
  logic                        dma_en;
  logic [31:0]                 src_base;
  logic [31:0]                 src_stride;
  logic                        op_en;

  // model state
  logic                        m_req_vld;
  pdp_rdma_csb_pkg::csb_req_t  m_req;
  logic                        m_producer;
  logic                        m_consumer;
  logic                        m_op [2];
  logic [31:0]                 m_fld [2][6];   // width, height, channel, dma_en, base, stride
  logic [`PDP_RDMA_OP_EN_DELAY-1:0] m_pipe;
  logic                        m_resp_valid;
  logic [33:0]                 m_resp;

  logic [31:0] seed = 32'h698c3d55;
  int          checks;
  int          errors;
  int          tests_run;
  int          tests_failed;
  int          test_err_start;

  pdp_rdma_reg_top dut_i (
    .nvdla_core_clk          (nvdla_core_clk),
    .nvdla_core_rstn         (nvdla_core_rstn),
    .csb2pdp_rdma_req_pvld   (req_pvld),
    .csb2pdp_rdma_req_pd     (req_pd),
    .csb2pdp_rdma_req_prdy   (req_prdy),
    .pdp_rdma2csb_resp_valid (resp_valid),
    .pdp_rdma2csb_resp_pd    (resp_pd),
    .dp2reg_done             (dp2reg_done),
    .reg2dp_cube_in_width    (cube_w),
    .reg2dp_cube_in_height   (cube_h),
    .reg2dp_cube_in_channel  (cube_c),
    .reg2dp_dma_en           (dma_en),
    .reg2dp_src_base_addr_low(src_base),
    .reg2dp_src_line_stride  (src_stride),
    .reg2dp_op_en            (op_en)
  );

  initial nvdla_core_clk = 1'b0;
  always #50 nvdla_core_clk = ~nvdla_core_clk;   // 100 ns period

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // writable bits per field index
  function automatic logic [31:0] field_mask(input int idx);
    if (idx < 3) begin
      return 32'h0000_1fff;
    end
    return (idx == 3) ? 32'h1 : 32'hffff_ffff;
  endfunction

  function automatic logic [1:0] status_code(input logic en, input logic consumed);
    if (!en) begin
      return 2'd0;
    end
    return consumed ? 2'd1 : 2'd2;   // running or pending
  endfunction

  // read data the register file should return for a byte offset
  function automatic logic [31:0] model_read(input logic [11:0] offs);
    logic [31:0] v;
    v = '0;
    if (offs == `PDP_RDMA_S_POINTER) begin
      v[0] = m_producer;
    end else if (offs == `PDP_RDMA_S_STATUS) begin
      v[1:0]   = status_code(m_op[0], !m_consumer);
      v[17:16] = status_code(m_op[1], m_consumer);
    end else if (offs == `PDP_RDMA_D_OP_ENABLE) begin
      v[0] = m_op[m_producer];
    end else if (offs >= `PDP_RDMA_D_CUBE_WIDTH && offs <= `PDP_RDMA_D_SRC_LINE_STRIDE) begin
      v = m_fld[m_producer][(offs - `PDP_RDMA_D_CUBE_WIDTH) >> 2];
    end
    return v;   // holes read zero
  endfunction

  task automatic compare_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %s got 0x%0h exp 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  ////////////////////////////////////////
  // cycle model
  ////////////////////////////////////////
  always @(posedge nvdla_core_clk or negedge nvdla_core_rstn) begin
    logic [11:0] offs;
    logic        g;
    if (!nvdla_core_rstn) begin
      m_req_vld    <= 1'b0;
      m_producer   <= 1'b0;
      m_consumer   <= 1'b0;
      m_pipe       <= '0;
      m_resp_valid <= 1'b0;
      m_resp       <= '0;
      for (int i = 0; i < 2; i++) begin
        m_op[i] <= 1'b0;
        for (int j = 0; j < 6; j++) begin
          m_fld[i][j] <= '0;
        end
      end
    end else begin
      offs = {m_req.addr[9:0], 2'b00};
      g    = m_producer;
      m_req_vld <= req_pvld;
      if (req_pvld) begin
        m_req <= req_pd;
      end
      // done flips consumer, clears its group, flushes the pipe
      if (dp2reg_done) begin
        m_consumer       <= ~m_consumer;
        m_op[m_consumer] <= 1'b0;
        m_pipe           <= '0;
      end else begin
        m_pipe <= {m_pipe[`PDP_RDMA_OP_EN_DELAY-2:0], m_op[m_consumer]};
      end
      if (m_req_vld && m_req.write) begin
        if (offs == `PDP_RDMA_S_POINTER) begin
          m_producer <= m_req.wdat[0];
        end else if (offs == `PDP_RDMA_D_OP_ENABLE && !m_op[g]) begin
          m_op[g] <= m_req.wdat[0];   // write wins over the done clear
        end else if (offs > `PDP_RDMA_D_OP_ENABLE && offs <= `PDP_RDMA_D_SRC_LINE_STRIDE
                     && !m_op[g]) begin
          m_fld[g][(offs - 12'h00c) >> 2] <= m_req.wdat & field_mask((offs - 12'h00c) >> 2);
        end
      end
      m_resp_valid <= m_req_vld && (!m_req.write || m_req.nposted);
      if (m_req_vld && !m_req.write) begin
        m_resp <= {1'b0, 1'b0, model_read(offs)};
      end else if (m_req_vld && m_req.nposted) begin
        m_resp <= {1'b1, 1'b0, 32'h0};
      end
    end
  end

  // outputs settle by the falling edge
  always @(negedge nvdla_core_clk) begin
    if (nvdla_core_rstn) begin
      compare_value("req_prdy", req_prdy, 1'b1);
      compare_value("resp_valid", resp_valid, m_resp_valid);
      if (m_resp_valid) begin
        compare_value("resp_pd", resp_pd, m_resp);
      end
      compare_value("reg2dp_op_en", op_en, m_pipe[`PDP_RDMA_OP_EN_DELAY-1]);
      compare_value("reg2dp_cube_in_width", cube_w, m_fld[m_consumer][0]);
      compare_value("reg2dp_cube_in_height", cube_h, m_fld[m_consumer][1]);
      compare_value("reg2dp_cube_in_channel", cube_c, m_fld[m_consumer][2]);
      compare_value("reg2dp_dma_en", dma_en, m_fld[m_consumer][3]);
      compare_value("reg2dp_src_base_addr_low", src_base, m_fld[m_consumer][4]);
      compare_value("reg2dp_src_line_stride", src_stride, m_fld[m_consumer][5]);
    end
  end

  ////////////////////////////////////////
  // stimulus helpers
  ////////////////////////////////////////
  task automatic bus_access(input logic wr, input logic [11:0] offs, input logic [31:0] data,
                            input logic np, output logic [31:0] rdat);
    pdp_rdma_csb_pkg::csb_req_t req;
    logic [31:0]                r;
    int                         n;
    r           = next_rand();
    req.level   = r[1:0];
    req.wrbe    = 4'hf;
    req.srcpriv = r[2];
    req.nposted = np;
    req.write   = wr;
    req.wdat    = data;
    req.addr    = {r[31:20], offs[11:2]};   // upper word bits are not decoded
    rdat        = '0;
    @(posedge nvdla_core_clk);
    req_pvld <= 1'b1;
    req_pd   <= req;
    @(posedge nvdla_core_clk);
    req_pvld <= 1'b0;
    if (wr && !np) begin
      // a posted write gets no response
      for (n = 0; n < 3; n++) begin
        @(negedge nvdla_core_clk);
      end
    end else begin
      @(negedge nvdla_core_clk);
      n = 1;
      while (!resp_valid && n < wait_limit) begin
        @(negedge nvdla_core_clk);
        n++;
      end
      if (!resp_valid) begin
        errors++;
        $display("no response to the request at offset 0x%0h within %0d cycles", offs, n);
      end else begin
        rdat = resp_pd[31:0];
      end
    end
  endtask

  task automatic pulse_done();
    @(posedge nvdla_core_clk);
    dp2reg_done <= 1'b1;
    @(posedge nvdla_core_clk);
    dp2reg_done <= 1'b0;
    @(negedge nvdla_core_clk);
  endtask

  // cycles from now until reg2dp_op_en is seen high
  task automatic count_rise(output int cyc);
    cyc = 0;
    while (!op_en && cyc < wait_limit) begin
      @(negedge nvdla_core_clk);
      cyc++;
    end
    if (!op_en) begin
      errors++;
      $display("reg2dp_op_en did not rise within %0d cycles", cyc);
    end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors != test_err_start) begin
      tests_failed++;
    end
    $display("test %0d %s: %s", tests_run, name, (errors == test_err_start) ? "ok" : "FAILED");
    test_err_start = errors;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////
  initial begin
    logic [31:0] rd;
    logic [31:0] exp;
    logic [11:0] offs;
    logic        t;
    int          idx;
    int          cyc;
    nvdla_core_rstn = 1'b0;
    req_pvld        = 1'b0;
    req_pd          = '0;
    dp2reg_done     = 1'b0;
    checks          = 0;
    errors          = 0;
    tests_run       = 0;
    tests_failed    = 0;
    test_err_start  = 0;
    repeat (2) @(posedge nvdla_core_clk);
    nvdla_core_rstn <= 1'b1;

    // reset values
    @(negedge nvdla_core_clk);
    compare_value("resp_valid", resp_valid, 1'b0);
    compare_value("reg2dp_op_en", op_en, 1'b0);
    compare_value("reg2dp cfg", {cube_w, cube_h, cube_c, dma_en, src_base, src_stride}, '0);
    bus_access(1'b0, `PDP_RDMA_S_STATUS, '0, 1'b0, rd);
    compare_value("status rdat", rd, 32'h0);
    finish_test("reset values");

    // random field writes to both groups with read-back and holes
    for (int p = 0; p < 2; p++) begin
      bus_access(1'b1, `PDP_RDMA_S_POINTER, p, 1'b1, rd);
      repeat (12) begin
        idx = next_rand() % 6;
        bus_access(1'b1, 12'h00c + idx * 4, next_rand(), next_rand() & 1, rd);
      end
      for (idx = 0; idx < 7; idx++) begin
        offs = `PDP_RDMA_D_OP_ENABLE + idx * 4;
        exp  = model_read(offs);
        bus_access(1'b0, offs, '0, 1'b0, rd);
        compare_value("readback rdat", rd, exp);
      end
    end
    repeat (6) begin
      offs = 12'h024 + ((next_rand() % 1000) << 2);
      bus_access(1'b0, offs, '0, 1'b0, rd);
      compare_value("unmapped rdat", rd, 32'h0);
    end
    finish_test("random writes and read-back");

    // enable group 0
    bus_access(1'b1, `PDP_RDMA_S_POINTER, 32'h0, 1'b1, rd);
    bus_access(1'b1, `PDP_RDMA_D_OP_ENABLE, 32'h1, 1'b1, rd);
    count_rise(cyc);
    compare_value("op_en rise cycles", cyc, 3);
    compare_value("reg2dp_src_line_stride", src_stride, m_fld[0][5]);
    bus_access(1'b0, `PDP_RDMA_S_STATUS, '0, 1'b0, rd);
    compare_value("status rdat", rd, 32'h0000_0001);   // g0 running, g1 idle
    finish_test("enable group 0");

    // a locked group drops writes and the other group takes them
    for (idx = 0; idx < 6; idx++) begin
      exp = m_fld[0][idx];   // value held before the write
      bus_access(1'b1, 12'h00c + idx * 4, next_rand(), 1'b1, rd);
      bus_access(1'b0, 12'h00c + idx * 4, '0, 1'b0, rd);
      compare_value("locked field rdat", rd, exp);
    end
    bus_access(1'b1, `PDP_RDMA_S_POINTER, 32'h1, 1'b1, rd);
    for (idx = 0; idx < 6; idx++) begin
      exp = next_rand();
      bus_access(1'b1, 12'h00c + idx * 4, exp, 1'b1, rd);
      bus_access(1'b0, 12'h00c + idx * 4, '0, 1'b0, rd);
      compare_value("open field rdat", rd, exp & field_mask(idx));
    end
    finish_test("locked group writes");

    // ping-pong through done pulses
    for (int i = 0; i < 4; i++) begin
      t = ~m_consumer;   // idle group gets the next layer
      bus_access(1'b1, `PDP_RDMA_S_POINTER, t, 1'b1, rd);
      for (idx = 0; idx < 6; idx++) begin
        bus_access(1'b1, 12'h00c + idx * 4, next_rand(), next_rand() & 1, rd);
      end
      bus_access(1'b1, `PDP_RDMA_D_OP_ENABLE, 32'h1, 1'b1, rd);
      bus_access(1'b0, `PDP_RDMA_S_STATUS, '0, 1'b0, rd);
      compare_value("status rdat", rd, t ? 32'h0002_0001 : 32'h0001_0002);
      pulse_done();
      compare_value("reg2dp_op_en after done", op_en, 1'b0);
      count_rise(cyc);
      compare_value("op_en rise cycles", cyc, 3);
      bus_access(1'b0, `PDP_RDMA_S_STATUS, '0, 1'b0, rd);
      compare_value("status rdat", rd, t ? 32'h0001_0000 : 32'h0000_0001);
    end
    pulse_done();   // nothing queued behind it
    bus_access(1'b0, `PDP_RDMA_S_STATUS, '0, 1'b0, rd);
    compare_value("status rdat", rd, 32'h0);
    compare_value("reg2dp_op_en idle", op_en, 1'b0);
    finish_test("ping-pong done sequence");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+source
source/pdp_rdma_csb_pkg.sv
source/pdp_rdma_reg_pkg.sv
source/pdp_rdma_reg_if.sv
source/pdp_rdma_csb_slave.sv
source/pdp_rdma_single_reg.sv
source/pdp_rdma_dual_reg.sv
source/pdp_rdma_ping_pong_ctrl.sv
source/pdp_rdma_reg_top.sv
sim/pdp_rdma_reg_tb.sv
